// ==== bench/spi_word_properties.sv ====
// SPI word peripheral checker with concurrent assertions on handshakes, FSM and counters
`timescale 1ns/1ps

module spi_word_properties #(
  parameter int word_bytes = 4
) (
  input logic                       clk,
  input logic                       resetn,
  input logic                       rx_valid,
  input logic                       rx_ready,
  input logic [8*word_bytes-1:0]    rx_data,
  input spi_word_pkg::frame_state_e state,
  input logic                       tx_take,
  input logic                       tx_pending,
  input logic [7:0]                 overrun_count
);

  import spi_word_pkg::*;

  // Receive word waits unchanged for the host
  rx_hold_stable: assert property (@(posedge clk) disable iff (resetn)
    (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)))
    else $error("rx stream changed before the transfer");

  // A frame only consumes a queued word
  take_needs_pending: assert property (@(posedge clk) disable iff (resetn)
    tx_take |-> tx_pending)
    else $error("tx_take without a pending word");

  // FS_HOLD is left only through a transfer
  hold_until_xfer: assert property (@(posedge clk) disable iff (resetn)
    (state == FS_HOLD && !(rx_valid && rx_ready)) |=> (state == FS_HOLD))
    else $error("FS_HOLD left without a transfer");

  // Saturating counter never goes back
  overrun_monotonic: assert property (@(posedge clk) disable iff (resetn)
    overrun_count >= $past(overrun_count))
    else $error("overrun_count decreased");

endmodule

bind spi_word_assembler spi_word_properties #(.word_bytes(word_bytes)) u_asm_props (
  .clk           (clk),
  .resetn        (resetn),
  .rx_valid      (rx_valid),
  .rx_ready      (rx_ready),
  .rx_data       (rx_data),
  .state         (state),
  .tx_take       (1'b0),
  .tx_pending    (1'b0),
  .overrun_count (8'd0)
);

bind spi_word_regs spi_word_properties #(.word_bytes(word_bytes)) u_regs_props (
  .clk           (clk),
  .resetn        (resetn),
  .rx_valid      (1'b0),
  .rx_ready      (1'b0),
  .rx_data       ('0),
  .state         (spi_word_pkg::FS_IDLE),
  .tx_take       (tx_take),
  .tx_pending    (tx_pending),
  .overrun_count (overrun_count)
);

// ==== bench/spi_word_tb.sv ====
// SPI word peripheral testbench, mode 0 controller model driving a table of frames
`timescale 1ns/1ps

module spi_word_tb;

  localparam int word_bytes = 4;
  localparam int word_w     = 8 * word_bytes;
  localparam int pos_w      = $clog2(word_w);
  localparam int num_rows   = 11;
  localparam int num_random = 4;
  // Clocks per sck half period
  localparam int half_sck   = 4;
  localparam int wait_limit = 400;

  // Host behavior on the receive stream
  typedef enum logic {
    RX_TAKE,
    RX_HOLD
  } rx_mode_e;

  typedef struct {
    string             name;
    logic [word_w-1:0] host_word;
    logic [word_w-1:0] ctrl_word;
    bit                queued;
    rx_mode_e          rx_mode;
    // Bits sent before cs rises, 0 for a full word
    int                abort_bits;
    logic [7:0]        exp_ovr;
  } frame_row_t;

  logic              clk;
  logic              resetn;
  logic              sck;
  logic              cs;
  logic              copi;
  logic              cipo;
  logic              tx_valid;
  logic              tx_ready;
  logic [word_w-1:0] tx_data;
  logic              rx_valid;
  logic              rx_ready;
  logic [word_w-1:0] rx_data;
  logic [7:0]        overrun_count;

  frame_row_t rows [num_rows];
  logic [31:0] lfsr_state;

  // Word still waiting in the DUT from a frame that was not taken
  logic              held;
  logic [word_w-1:0] held_word;

  spi_word_top #(.word_bytes(word_bytes)) DUT (
    .clk           (clk),
    .resetn        (resetn),
    .sck           (sck),
    .cs            (cs),
    .copi          (copi),
    .cipo          (cipo),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .tx_data       (tx_data),
    .rx_valid      (rx_valid),
    .rx_ready      (rx_ready),
    .rx_data       (rx_data),
    .overrun_count (overrun_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      fail_stop($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic random_word(output logic [word_w-1:0] w);
    w = '0;
    for (int i = 0; i < word_w; i++) begin
      w = {lfsr_state[0], w[word_w-1:1]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Word bit carried by wire bit j, bytes little-endian and MSB first
  function automatic logic [pos_w-1:0] wire_pos(input int j);
    return pos_w'(8 * (j / 8) + 7 - (j % 8));
  endfunction

  // Mode 0 controller, copi set while sck is low, cipo captured on the rise
  task automatic spi_frame(input logic [word_w-1:0] ctrl_word, input int nbits,
                           output logic [word_w-1:0] captured,
                           output logic [word_w-1:0] mask);
    logic [pos_w-1:0] pos;
    captured = '0;
    mask     = '0;
    cs       = 1'b0;
    copi     = ctrl_word[wire_pos(0)];
    // Room for cs_start to reach the tx latch
    wait_clocks(2 * half_sck);
    for (int j = 0; j < nbits; j++) begin
      pos  = wire_pos(j);
      copi = ctrl_word[pos];
      wait_clocks(half_sck);
      sck           = 1'b1;
      captured[pos] = cipo;
      mask[pos]     = 1'b1;
      wait_clocks(half_sck);
      sck = 1'b0;
    end
    // Let the last byte pass the synchronizer before cs rises
    wait_clocks(2 * half_sck);
    cs   = 1'b1;
    copi = 1'b0;
    wait_clocks(2 * half_sck);
  endtask

  task automatic queue_word(input string name, input logic [word_w-1:0] w);
    int waited;
    waited   = 0;
    tx_data  = w;
    tx_valid = 1'b1;
    while (!tx_ready) begin
      if (waited == wait_limit) begin
        fail_stop($sformatf("Timeout waiting for tx_ready in frame %s", name));
      end
      wait_clocks(1);
      waited++;
    end
    // Both high across the next edge
    wait_clocks(1);
    tx_valid = 1'b0;
    check_value($sformatf("%s tx_ready after queue", name), 64'(1'b0), 64'(tx_ready));
  endtask

  task automatic wait_rx_valid(input string name);
    int waited;
    waited = 0;
    while (!rx_valid) begin
      if (waited == wait_limit) begin
        fail_stop($sformatf("Timeout waiting for rx_valid in frame %s", name));
      end
      wait_clocks(1);
      waited++;
    end
  endtask

  // Valid and data stay put while rx_ready is low
  task automatic check_rx_held(input string name, input logic [word_w-1:0] expected);
    for (int i = 0; i < 3; i++) begin
      check_value($sformatf("%s rx_valid", name), 64'(1'b1), 64'(rx_valid));
      check_value($sformatf("%s rx_data", name), 64'(expected), 64'(rx_data));
      wait_clocks(1);
    end
  endtask

  task automatic take_rx(input string name);
    rx_ready = 1'b1;
    wait_clocks(1);
    rx_ready = 1'b0;
    check_value($sformatf("%s rx_valid after take", name), 64'(1'b0), 64'(rx_valid));
  endtask

  task automatic set_row(input int idx, input string name,
                         input logic [word_w-1:0] host_word,
                         input logic [word_w-1:0] ctrl_word, input bit queued,
                         input rx_mode_e rx_mode, input int abort_bits,
                         input logic [7:0] exp_ovr);
    rows[idx].name       = name;
    rows[idx].host_word  = host_word;
    rows[idx].ctrl_word  = ctrl_word;
    rows[idx].queued     = queued;
    rows[idx].rx_mode    = rx_mode;
    rows[idx].abort_bits = abort_bits;
    rows[idx].exp_ovr    = exp_ovr;
  endtask

  task automatic fill_table();
    logic [word_w-1:0] host_w;
    logic [word_w-1:0] ctrl_w;
    // Nothing queued, cipo must stay zero
    set_row(0, "no_tx_queued", 32'h0000_0000, 32'ha1b2_c3d4, 1'b0, RX_TAKE, 0, 8'd0);
    set_row(1, "tx_queued", 32'h5a3c_0ff1, 32'h0123_4567, 1'b1, RX_TAKE, 0, 8'd0);
    // Cut in the middle of byte 1
    set_row(2, "abort_mid_byte", 32'h0bad_f00d, 32'hffff_0000, 1'b1, RX_TAKE, 13, 8'd0);
    set_row(3, "after_abort", 32'h0000_0000, 32'h1357_9bdf, 1'b0, RX_TAKE, 0, 8'd0);
    // Two frames without a transfer in between
    set_row(4, "hold_first", 32'h1111_2222, 32'hcafe_babe, 1'b1, RX_HOLD, 0, 8'd0);
    set_row(5, "hold_second", 32'h0000_0000, 32'hdead_beef, 1'b0, RX_TAKE, 0, 8'd1);
    set_row(6, "after_hold", 32'h8765_4321, 32'h7654_3210, 1'b1, RX_TAKE, 0, 8'd1);
    for (int i = 0; i < num_random; i++) begin
      random_word(host_w);
      random_word(ctrl_w);
      set_row(7 + i, $sformatf("random_%0d", i), host_w, ctrl_w, 1'b1, RX_TAKE, 0, 8'd1);
    end
  endtask

  task automatic run_row(input int r);
    logic [word_w-1:0] exp_tx;
    logic [word_w-1:0] exp_rx;
    logic [word_w-1:0] captured;
    logic [word_w-1:0] mask;
    int                nbits;
    exp_tx = rows[r].queued ? rows[r].host_word : '0;
    nbits  = (rows[r].abort_bits > 0) ? rows[r].abort_bits : word_w;
    if (rows[r].queued) begin
      queue_word(rows[r].name, rows[r].host_word);
    end
    spi_frame(rows[r].ctrl_word, nbits, captured, mask);
    check_value($sformatf("%s cipo", rows[r].name), 64'(exp_tx & mask), 64'(captured));
    // Slot freed once the frame started
    check_value($sformatf("%s tx_ready after frame", rows[r].name), 64'(1'b1),
                64'(tx_ready));
    if (rows[r].abort_bits > 0) begin
      // Partial word never shows up
      for (int i = 0; i < 4; i++) begin
        check_value($sformatf("%s rx_valid", rows[r].name), 64'(1'b0), 64'(rx_valid));
        wait_clocks(1);
      end
    end else begin
      // A held word wins over the one that just completed
      exp_rx = held ? held_word : rows[r].ctrl_word;
      wait_rx_valid(rows[r].name);
      check_rx_held(rows[r].name, exp_rx);
      if (rows[r].rx_mode == RX_TAKE) begin
        take_rx(rows[r].name);
        held = 1'b0;
      end else begin
        held      = 1'b1;
        held_word = exp_rx;
      end
    end
    check_value($sformatf("%s overrun_count", rows[r].name), 64'(rows[r].exp_ovr),
                64'(overrun_count));
  endtask

  initial begin
    sck        = 1'b0;
    cs         = 1'b1;
    copi       = 1'b0;
    tx_valid   = 1'b0;
    tx_data    = '0;
    rx_ready   = 1'b0;
    resetn     = 1'b1;
    held       = 1'b0;
    held_word  = '0;
    lfsr_state = 32'h33b0_3d1e;
    fill_table();
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b0;
    wait_clocks(2);
    // Idle state after reset
    check_value("reset rx_valid", 64'(1'b0), 64'(rx_valid));
    check_value("reset tx_ready", 64'(1'b1), 64'(tx_ready));
    check_value("reset overrun_count", 64'(8'd0), 64'(overrun_count));
    check_value("reset cipo", 64'(1'b0), 64'(cipo));
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== hw/spi_byte_shifter.sv ====
// SPI mode 0 byte shifter that moves bits MSB first and flags each finished byte
`timescale 1ns/1ps

module spi_byte_shifter (
  input  logic                      clk,
  input  logic                      resetn,
  input  spi_word_pkg::pin_sample_t sample,
  input  logic [7:0]                tx_byte,
  output logic                      cipo,
  output spi_word_pkg::byte_evt_t   evt
);

  // Receive shift register
  logic [7:0] rx_shift;

  // Rising edge count that wraps to 0 after eight bits
  logic [2:0] rx_cnt;

  // Index of the bit on cipo, counting down from 7
  logic [2:0] tx_cnt;

  // Registered byte done pulse
  logic done_q;

  // Data is presented before the first rising edge
  assign cipo = tx_byte[tx_cnt];

  assign evt.rx_byte = rx_shift;
  assign evt.done    = done_q;

  // Receive side samples copi on rising sck
  always_ff @(posedge clk) begin
    if (sample.cs_active && sample.sck_rise) begin
      rx_shift <= {rx_shift[6:0], sample.copi};
    end
  end

  // Bit counters and byte event
  always_ff @(posedge clk) begin
    if (resetn) begin
      rx_cnt <= 3'd0;
      tx_cnt <= 3'd7;
      done_q <= 1'b0;
    end else if (sample.cs_active) begin
      if (sample.sck_rise) begin
        rx_cnt <= rx_cnt + 3'd1;
      end
      if (sample.sck_fall) begin
        // Rolls over from 0 to 7 at the byte boundary
        tx_cnt <= tx_cnt - 3'd1;
      end
      // Byte ends on the falling edge of bit 8
      // rx_cnt has already wrapped after the eighth rise
      done_q <= sample.sck_fall && (tx_cnt == 3'd0) && (rx_cnt == 3'd0);
    end else begin
      // Interrupted transfer returns the counters to their start values
      rx_cnt <= 3'd0;
      tx_cnt <= 3'd7;
      done_q <= 1'b0;
    end
  end

endmodule

// ==== hw/spi_pin_sync.sv ====
// SPI pin synchronizer, brings sck, cs and copi into clk and forms edge pulses
`timescale 1ns/1ps

module spi_pin_sync (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      sck,
  input  logic                      cs,
  input  logic                      copi,
  output spi_word_pkg::pin_sample_t sample
);

  // Two flops per pin
  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;

  // Previous synchronized levels for edge detection
  logic sck_prev;
  logic cs_prev;

  always_ff @(posedge clk) begin
    if (resetn) begin
      // Idle bus: sck low, cs high
      sck_sync  <= 2'b00;
      cs_sync   <= 2'b11;
      copi_sync <= 2'b00;
      sck_prev  <= 1'b0;
      cs_prev   <= 1'b1;
      sample    <= '0;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      cs_sync   <= {cs_sync[0], cs};
      copi_sync <= {copi_sync[0], copi};
      sck_prev  <= sck_sync[1];
      cs_prev   <= cs_sync[1];
      // Edge register, third stage of the path
      sample.sck_rise  <= sck_sync[1] & ~sck_prev;
      sample.sck_fall  <= ~sck_sync[1] & sck_prev;
      sample.cs_active <= ~cs_sync[1];
      sample.cs_start  <= ~cs_sync[1] & cs_prev;
      sample.copi      <= copi_sync[1];
    end
  end

endmodule

// ==== hw/spi_word_assembler.sv ====
// SPI word assembler, builds little-endian words from bytes and feeds the receive stream
`timescale 1ns/1ps

module spi_word_assembler #(
  parameter int word_bytes = 4
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  spi_word_pkg::pin_sample_t sample,
  input  spi_word_pkg::byte_evt_t   evt,
  input  logic [8*word_bytes-1:0]   tx_word,
  input  logic                      tx_pending,
  output logic                      tx_take,
  output logic [7:0]                tx_byte,
  output logic                      overrun,
  output logic                      rx_valid,
  input  logic                      rx_ready,
  output logic [8*word_bytes-1:0]   rx_data
);

  import spi_word_pkg::*;

  localparam int word_w = 8 * word_bytes;
  localparam int idx_w  = $clog2(word_bytes);
  localparam logic [idx_w-1:0] last_idx = idx_w'(word_bytes - 1);

  frame_state_e state;

  // Word sent during the current frame
  logic [word_w-1:0] tx_latch;

  // Partial receive word, new bytes enter at the top
  logic [word_w-1:0] rx_shift;

  // Byte position within the word
  logic [idx_w-1:0] byte_cnt;
  logic [idx_w-1:0] tx_idx;

  logic word_done;
  logic xfer;

  assign rx_valid  = (state == FS_HOLD);
  assign xfer      = rx_valid && rx_ready;
  assign word_done = evt.done && sample.cs_active && (byte_cnt == last_idx);

  // Consume the pending word as the frame opens
  assign tx_take = sample.cs_start && tx_pending;

  // Word finished while the previous one still waits
  assign overrun = word_done && (state == FS_HOLD) && !xfer;

  // Look one byte ahead during done so cipo switches with the bit counter wrap
  always_comb begin
    tx_idx = byte_cnt;
    if (evt.done) begin
      tx_idx = (byte_cnt == last_idx) ? '0 : byte_cnt + idx_w'(1);
    end
  end

  assign tx_byte = tx_latch[8*tx_idx +: 8];

  // Transmit word latch, zeros when nothing is queued
  always_ff @(posedge clk) begin
    if (resetn) begin
      tx_latch <= '0;
    end else if (sample.cs_start) begin
      tx_latch <= tx_pending ? tx_word : '0;
    end
  end

  // Byte counter and receive shift
  always_ff @(posedge clk) begin
    if (resetn) begin
      byte_cnt <= '0;
    end else if (!sample.cs_active) begin
      // Partial word dropped
      byte_cnt <= '0;
    end else if (evt.done) begin
      byte_cnt <= (byte_cnt == last_idx) ? '0 : byte_cnt + idx_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (evt.done) begin
      rx_shift <= {evt.rx_byte, rx_shift[word_w-1:8]};
    end
  end

  // Completed word goes out, unless one is still held
  always_ff @(posedge clk) begin
    if (word_done && (state != FS_HOLD || xfer)) begin
      rx_data <= {evt.rx_byte, rx_shift[word_w-1:8]};
    end
  end

  // Frame and hold FSM
  always_ff @(posedge clk) begin
    if (resetn) begin
      state <= FS_IDLE;
    end else begin
      case (state)
        FS_IDLE: begin
          if (sample.cs_start) begin
            state <= FS_ACTIVE;
          end
        end
        FS_ACTIVE: begin
          if (word_done) begin
            state <= FS_HOLD;
          end else if (!sample.cs_active) begin
            state <= FS_IDLE;
          end
        end
        FS_HOLD: begin
          // Leave only when the host takes the word
          if (xfer) begin
            if (word_done) begin
              state <= FS_HOLD;
            end else if (sample.cs_active) begin
              state <= FS_ACTIVE;
            end else begin
              state <= FS_IDLE;
            end
          end
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/spi_word_pkg.sv ====
// SPI word peripheral shared types for pin samples, byte events and frame state
package spi_word_pkg;

  // Pin events after synchronization, all aligned to clk
  typedef struct packed {
    // One-cycle pulse on a rising sck
    logic sck_rise;
    // One-cycle pulse on a falling sck
    logic sck_fall;
    // Level, high while cs is low on the pin
    logic cs_active;
    // One-cycle pulse when cs falls
    logic cs_start;
    // Synchronized copi level
    logic copi;
  } pin_sample_t;

  // Byte result from the shifter
  typedef struct packed {
    // Last received byte, MSB came first on the wire
    logic [7:0] rx_byte;
    // One-cycle pulse when a full byte has been shifted
    logic       done;
  } byte_evt_t;

  // Word assembler states
  typedef enum logic [1:0] {
    FS_IDLE,
    FS_ACTIVE,
    FS_HOLD
  } frame_state_e;

endpackage

// ==== hw/spi_word_regs.sv ====
// SPI word register block, one-entry transmit holding register and overrun counter
`timescale 1ns/1ps

module spi_word_regs #(
  parameter int word_bytes = 4
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    tx_valid,
  output logic                    tx_ready,
  input  logic [8*word_bytes-1:0] tx_data,
  input  logic                    tx_take,
  input  logic                    overrun,
  output logic [8*word_bytes-1:0] tx_word,
  output logic                    tx_pending,
  output logic [7:0]              overrun_count
);

  logic accept;

  // Room for one word only
  assign tx_ready = !tx_pending;
  assign accept   = tx_valid && tx_ready;

  // Payload, qualified by tx_pending
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_word <= tx_data;
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      tx_pending <= 1'b0;
    end else if (accept) begin
      tx_pending <= 1'b1;
    end else if (tx_take) begin
      // Frame started, slot free on the next cycle
      tx_pending <= 1'b0;
    end
  end

  // Saturates at 255
  always_ff @(posedge clk) begin
    if (resetn) begin
      overrun_count <= 8'd0;
    end else if (overrun && overrun_count != 8'hff) begin
      overrun_count <= overrun_count + 8'd1;
    end
  end

endmodule

// ==== hw/spi_word_top.sv ====
// SPI word peripheral top, mode 0 pins to host valid/ready word streams
`timescale 1ns/1ps

module spi_word_top #(
  parameter int word_bytes = 4
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    sck,
  input  logic                    cs,
  input  logic                    copi,
  output logic                    cipo,
  input  logic                    tx_valid,
  output logic                    tx_ready,
  input  logic [8*word_bytes-1:0] tx_data,
  output logic                    rx_valid,
  input  logic                    rx_ready,
  output logic [8*word_bytes-1:0] rx_data,
  output logic [7:0]              overrun_count
);

  import spi_word_pkg::*;

  pin_sample_t sample;
  byte_evt_t   evt;

  logic [7:0]              tx_byte;
  logic [8*word_bytes-1:0] tx_word;
  logic                    tx_pending;
  logic                    tx_take;
  logic                    overrun;

  // Pin front end
  spi_pin_sync u_sync (
    .clk    (clk),
    .resetn (resetn),
    .sck    (sck),
    .cs     (cs),
    .copi   (copi),
    .sample (sample)
  );

  spi_byte_shifter u_shifter (
    .clk     (clk),
    .resetn  (resetn),
    .sample  (sample),
    .tx_byte (tx_byte),
    .cipo    (cipo),
    .evt     (evt)
  );

  spi_word_assembler #(.word_bytes(word_bytes)) u_assembler (
    .clk        (clk),
    .resetn     (resetn),
    .sample     (sample),
    .evt        (evt),
    .tx_word    (tx_word),
    .tx_pending (tx_pending),
    .tx_take    (tx_take),
    .tx_byte    (tx_byte),
    .overrun    (overrun),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .rx_data    (rx_data)
  );

  // Host side registers
  spi_word_regs #(.word_bytes(word_bytes)) u_regs (
    .clk           (clk),
    .resetn        (resetn),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .tx_data       (tx_data),
    .tx_take       (tx_take),
    .overrun       (overrun),
    .tx_word       (tx_word),
    .tx_pending    (tx_pending),
    .overrun_count (overrun_count)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run, exit status is nonzero when the testbench fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f spi_word_top.f --top-module spi_word_tb \
  -Mdir obj_dir -o spi_word_sim &&
./obj_dir/spi_word_sim || exit 1

// ==== spi_word_top.f ====
hw/spi_word_pkg.sv
hw/spi_pin_sync.sv
hw/spi_byte_shifter.sv
hw/spi_word_assembler.sv
hw/spi_word_regs.sv
hw/spi_word_top.sv
bench/spi_word_properties.sv
bench/spi_word_tb.sv
